/* dcache.f */
dcache_pkg.sv
mem_bus_pkg.sv
victim_buffer.sv
l1_line_array.sv
dcache_ctrl.sv
dcache_top.sv
dcache_checker.sv
tb_dcache.sv

/* Makefile */
VERILATOR   ?= verilator
TOP         := tb_dcache
FILELIST    := dcache.f
OBJ_DIR     := obj_dir
BUILD_FLAGS := --binary --timing --timescale 1ns/100ps -j 0 --Mdir $(OBJ_DIR)
LINT_FLAGS  := --lint-only --timing --timescale 1ns/100ps

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASSED"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* tb_dcache.sv */
// testbench of the write-back data cache: clock, reset, LFSR stimulus and a line memory model
// directed tests run first, then a random run; dcache_checker does the comparing

`timescale 1ns/100ps

module tb_dcache import dcache_pkg::*, mem_bus_pkg::*; ();

    localparam int NUM_DIRECTED   = 18;
    localparam int NUM_RANDOM     = 2000;
    localparam int TIMEOUT_CYCLES = (NUM_DIRECTED + NUM_RANDOM) * (8 + 12) + 100;

    logic         clk;
    logic         rstn;
    logic         cpu_req_valid;
    cpu_req_t     cpu_req;
    logic         cpu_ready;
    logic         cpu_resp_valid;
    logic [31:0]  cpu_rdata;
    logic         mem_req_valid;
    mem_req_t     mem_req;
    logic         mem_resp_valid;
    line_t        mem_resp_line;

    logic [127:0] test_name;
    int           expect_lat;
    logic         reads_allowed;
    int           mismatches;
    int           failures;
    logic [15:0]  lfsr_q = 16'd44433;

    // backing store, lines that were written back
    line_t        mem_lines [line_addr_t];

    dcache_top #(
        .VICTIM_ENTRIES (2)
    ) dcache_top_i (
        .clk            (clk),
        .rstn           (rstn),
        .cpu_req_valid  (cpu_req_valid),
        .cpu_req        (cpu_req),
        .cpu_ready      (cpu_ready),
        .cpu_resp_valid (cpu_resp_valid),
        .cpu_rdata      (cpu_rdata),
        .mem_req_valid  (mem_req_valid),
        .mem_req        (mem_req),
        .mem_resp_valid (mem_resp_valid),
        .mem_resp_line  (mem_resp_line)
    );

    dcache_checker checker_i (
        .clk            (clk),
        .rstn           (rstn),
        .cpu_req_valid  (cpu_req_valid),
        .cpu_req        (cpu_req),
        .cpu_ready      (cpu_ready),
        .cpu_resp_valid (cpu_resp_valid),
        .cpu_rdata      (cpu_rdata),
        .mem_req_valid  (mem_req_valid),
        .mem_req        (mem_req),
        .mem_resp_valid (mem_resp_valid),
        .test_name      (test_name),
        .expect_lat     (expect_lat),
        .reads_allowed  (reads_allowed),
        .mismatches     (mismatches),
        .failures       (failures)
    );

    // 16-bit Galois LFSR, one step per bit
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hb400;
        end
        return s >> 1;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r      = {r[30:0], lfsr_q[0]};
            lfsr_q = lfsr_next(lfsr_q);
        end
        return r;
    endfunction

    function automatic logic [31:0] fill_word(input logic [31:0] byte_addr);
        return (byte_addr * 32'h9e37_79b9) ^ 32'h5a5a_a5a5;
    endfunction

    function automatic line_t read_line(input line_addr_t la);
        line_t l;
        if (mem_lines.exists(la)) begin
            return mem_lines[la];
        end
        for (int w = 0; w < 16; w++) begin
            l[w*32 +: 32] = fill_word({la, 4'(w), 2'b00});
        end
        return l;
    endfunction

    function automatic cache_addr_t make_addr(input logic [TAG_W-1:0] tag,
                                              input logic [INDEX_W-1:0] index,
                                              input logic [WORD_W-1:0] word);
        cache_addr_t a;
        a.tag      = tag;
        a.index    = index;
        a.word     = word;
        a.byte_off = 2'b00;
        return a;
    endfunction

    // one CPU access, called and returning on a falling edge
    task automatic access(input logic write, input cache_addr_t addr, input logic [31:0] data);
        while (!cpu_ready) begin
            @(negedge clk);
        end
        cpu_req.addr  = addr;
        cpu_req.write = write;
        cpu_req.wdata = data;
        cpu_req_valid = 1'b1;
        @(negedge clk);
        cpu_req_valid = 1'b0;
        while (!cpu_resp_valid) begin
            @(negedge clk);
        end
        @(negedge clk);
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // answers one read at a time after 1 to 8 cycles
    initial begin : memory_model
        line_addr_t rd_addr;
        int         rd_wait;
        logic       rd_busy;
        rd_busy        = 1'b0;
        mem_resp_valid = 1'b0;
        mem_resp_line  = '0;
        forever begin
            @(posedge clk);
            if (rstn && mem_req_valid) begin
                if (mem_req.write) begin
                    mem_lines[mem_req.addr] = mem_req.line;
                end else begin
                    rd_addr = mem_req.addr;
                    rd_wait = 1 + int'(rand_bits(3));
                    rd_busy = 1'b1;
                end
            end
            @(negedge clk);
            mem_resp_valid = 1'b0;
            if (rd_busy) begin
                rd_wait--;
                if (rd_wait == 0) begin
                    rd_busy        = 1'b0;
                    mem_resp_valid = 1'b1;
                    mem_resp_line  = read_line(rd_addr);
                end
            end
        end
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        rstn          = 1'b0;
        cpu_req_valid = 1'b0;
        cpu_req       = '0;
        test_name     = "reset";
        expect_lat    = 0;
        reads_allowed = 1'b1;
        repeat (8) @(negedge clk);
        rstn = 1'b1;
        @(negedge clk);

        // write miss, then the repeat read must hit in one cycle
        test_name = "write_read";
        access(1'b1, make_addr(20'h00100, 6'd1, 4'd3), 32'hcafe_0001);
        access(1'b0, make_addr(20'h00100, 6'd1, 4'd3), 32'h0);
        expect_lat = 1;
        access(1'b0, make_addr(20'h00100, 6'd1, 4'd3), 32'h0);
        expect_lat = 0;

        // two tags on one index, served by swaps once both were fetched
        test_name = "victim_hit";
        access(1'b0, make_addr(20'h00200, 6'd2, 4'd0), 32'h0);
        access(1'b0, make_addr(20'h00201, 6'd2, 4'd0), 32'h0);
        reads_allowed = 1'b0;
        expect_lat    = 2;
        for (int i = 0; i < 4; i++) begin
            access(i < 2, make_addr(20'h00200, 6'd2, 4'd0), 32'ha000_0000 + i);
            access(1'b0, make_addr(20'h00201, 6'd2, 4'd0), 32'h0);
        end
        expect_lat    = 0;
        reads_allowed = 1'b1;

        // fourth conflicting write pushes the first dirty line out of the 2-entry buffer
        test_name = "dirty_wb";
        for (int i = 0; i < 4; i++) begin
            access(1'b1, make_addr(20'h00300 + 20'(i), 6'd3, 4'd7), 32'hd000_0000 + i);
        end
        access(1'b0, make_addr(20'h00300, 6'd3, 4'd7), 32'h0);

        // small tag and index pool keeps conflicts frequent
        test_name = "random";
        repeat (NUM_RANDOM) begin
            logic               wr;
            logic [TAG_W-1:0]   tag;
            logic [INDEX_W-1:0] index;
            logic [WORD_W-1:0]  word;
            logic [31:0]        data;
            wr    = 1'(rand_bits(1));
            tag   = 20'h00400 + 20'(rand_bits(2));
            index = 6'd8 + 6'(rand_bits(2));
            word  = 4'(rand_bits(4));
            data  = rand_bits(32);
            access(wr, make_addr(tag, index, word), data);
        end

        @(negedge clk);
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* dcache_checker.sv */
// watches the CPU and memory ports of the data cache and compares them with a flat word model
// counts value mismatches and other failures for the closing report of the testbench

`timescale 1ns/100ps

module dcache_checker import dcache_pkg::*, mem_bus_pkg::*; (
    input  logic         clk,
    input  logic         rstn,
    input  logic         cpu_req_valid,
    input  cpu_req_t     cpu_req,
    input  logic         cpu_ready,
    input  logic         cpu_resp_valid,
    input  logic [31:0]  cpu_rdata,
    input  logic         mem_req_valid,
    input  mem_req_t     mem_req,
    input  logic         mem_resp_valid,
    input  logic [127:0] test_name,
    input  int           expect_lat,
    input  logic         reads_allowed,
    output int           mismatches,
    output int           failures
);

    // flat word model keyed by word address
    logic [31:0] words [logic [29:0]];
    int          mism_cnt = 0;
    int          fail_cnt = 0;
    logic        started = 1'b0;
    logic        pending = 1'b0;
    logic        rd_pending = 1'b0;
    logic        req_write;
    logic [31:0] exp_data;
    int          req_lat;
    int          lat_cnt;

    assign mismatches = mism_cnt;
    assign failures   = fail_cnt;

    // same pattern as the memory model uses for lines never written
    function automatic logic [31:0] fill_word(input logic [31:0] byte_addr);
        return (byte_addr * 32'h9e37_79b9) ^ 32'h5a5a_a5a5;
    endfunction

    function automatic logic [31:0] model_word(input logic [29:0] word_addr);
        if (words.exists(word_addr)) begin
            return words[word_addr];
        end
        return fill_word({word_addr, 2'b00});
    endfunction

    // every word of a written-back line must match the model
    task automatic check_writeback();
        logic [29:0] wa;
        logic [31:0] exp;
        logic [31:0] act;
        for (int w = 0; w < 16; w++) begin
            wa  = {mem_req.addr, 4'(w)};
            exp = model_word(wa);
            act = mem_req.line[w*32 +: 32];
            if (act !== exp) begin
                $display("mismatch %0s write-back line %h word %0d expected %h actual %h",
                         test_name, mem_req.addr, w, exp, act);
                mism_cnt++;
            end
        end
    endtask

    always @(posedge clk) begin
        if (!rstn) begin
            started    = 1'b0;
            pending    = 1'b0;
            rd_pending = 1'b0;
        end else begin
            // first cycle out of reset
            if (!started) begin
                started = 1'b1;
                if (!cpu_ready || cpu_resp_valid || mem_req_valid) begin
                    $display("error in %0s: cache ports are not idle after reset", test_name);
                    fail_cnt++;
                end
            end
            if (pending) begin
                lat_cnt++;
                // no new request may be taken while one is open
                if (cpu_ready) begin
                    $display("error in %0s: cpu_ready is high while a request is open",
                             test_name);
                    fail_cnt++;
                end
            end
            if (cpu_resp_valid) begin
                if (!pending) begin
                    $display("error in %0s: CPU response without a request", test_name);
                    fail_cnt++;
                end else begin
                    if (!req_write && cpu_rdata !== exp_data) begin
                        $display("mismatch %0s read data expected %h actual %h",
                                 test_name, exp_data, cpu_rdata);
                        mism_cnt++;
                    end
                    if (req_lat != 0 && lat_cnt != req_lat) begin
                        $display("mismatch %0s latency expected %0d actual %0d",
                                 test_name, req_lat, lat_cnt);
                        mism_cnt++;
                    end
                end
                pending = 1'b0;
            end
            if (cpu_req_valid && cpu_ready) begin
                pending   = 1'b1;
                lat_cnt   = 0;
                req_write = cpu_req.write;
                req_lat   = expect_lat;
                if (cpu_req.write) begin
                    words[{cpu_req.addr.tag, cpu_req.addr.index, cpu_req.addr.word}] =
                        cpu_req.wdata;
                end else begin
                    exp_data = model_word({cpu_req.addr.tag, cpu_req.addr.index,
                                           cpu_req.addr.word});
                end
            end
            if (mem_resp_valid) begin
                rd_pending = 1'b0;
            end
            if (mem_req_valid) begin
                if (mem_req.write) begin
                    check_writeback();
                end else begin
                    if (rd_pending) begin
                        $display("error in %0s: memory read issued while another is open",
                                 test_name);
                        fail_cnt++;
                    end
                    if (!reads_allowed) begin
                        $display("error in %0s: memory read issued for a victim buffer line",
                                 test_name);
                        fail_cnt++;
                    end
                    rd_pending = 1'b1;
                end
            end
        end
    end

endmodule

/* dcache_top.sv */
// top of the write-back data cache: controller, direct-mapped L1 array and victim buffer
// VICTIM_ENTRIES sets the victim buffer depth (2, 4 or 8)

`timescale 1ns/100ps

module dcache_top import dcache_pkg::*, mem_bus_pkg::*; #(
    parameter int VICTIM_ENTRIES = 2
) (
    input  logic        clk,
    input  logic        rstn,
    input  logic        cpu_req_valid,
    input  cpu_req_t    cpu_req,
    output logic        cpu_ready,
    output logic        cpu_resp_valid,
    output logic [31:0] cpu_rdata,
    output logic        mem_req_valid,
    output mem_req_t    mem_req,
    input  logic        mem_resp_valid,
    input  line_t       mem_resp_line
);

    // controller to L1 array
    logic [INDEX_W-1:0] l1_index;
    logic               l1_we;
    logic [TAG_W-1:0]   l1_w_tag;
    line_t              l1_w_line;
    logic               l1_w_dirty;
    logic [TAG_W-1:0]   l1_r_tag;
    logic               l1_r_valid;
    logic               l1_r_dirty;
    line_t              l1_r_line;

    // controller to victim buffer
    line_addr_t vb_r_key;
    logic       vb_insert;
    line_addr_t vb_w_key;
    line_t      vb_w_line;
    logic       vb_w_dirty;
    logic       vb_invalidate;
    logic       victim_hit;
    line_t      victim_line;
    logic       victim_dirty;
    logic       evict_valid;
    line_addr_t evict_key;
    line_t      evict_line;
    logic       evict_dirty;

    dcache_ctrl dcache_ctrl_i (
        .clk            (clk),
        .rstn           (rstn),
        .cpu_req_valid  (cpu_req_valid),
        .cpu_req        (cpu_req),
        .cpu_ready      (cpu_ready),
        .cpu_resp_valid (cpu_resp_valid),
        .cpu_rdata      (cpu_rdata),
        .l1_index       (l1_index),
        .l1_we          (l1_we),
        .l1_w_tag       (l1_w_tag),
        .l1_w_line      (l1_w_line),
        .l1_w_dirty     (l1_w_dirty),
        .l1_r_tag       (l1_r_tag),
        .l1_r_valid     (l1_r_valid),
        .l1_r_dirty     (l1_r_dirty),
        .l1_r_line      (l1_r_line),
        .vb_r_key       (vb_r_key),
        .vb_insert      (vb_insert),
        .vb_w_key       (vb_w_key),
        .vb_w_line      (vb_w_line),
        .vb_w_dirty     (vb_w_dirty),
        .vb_invalidate  (vb_invalidate),
        .victim_hit     (victim_hit),
        .victim_line    (victim_line),
        .victim_dirty   (victim_dirty),
        .evict_valid    (evict_valid),
        .evict_key      (evict_key),
        .evict_line     (evict_line),
        .evict_dirty    (evict_dirty),
        .mem_req_valid  (mem_req_valid),
        .mem_req        (mem_req),
        .mem_resp_valid (mem_resp_valid),
        .mem_resp_line  (mem_resp_line)
    );

    l1_line_array l1_line_array_i (
        .clk     (clk),
        .rstn    (rstn),
        .index   (l1_index),
        .we      (l1_we),
        .w_tag   (l1_w_tag),
        .w_line  (l1_w_line),
        .w_dirty (l1_w_dirty),
        .r_tag   (l1_r_tag),
        .r_valid (l1_r_valid),
        .r_dirty (l1_r_dirty),
        .r_line  (l1_r_line)
    );

    victim_buffer #(
        .VICTIM_ENTRIES (VICTIM_ENTRIES)
    ) victim_buffer_i (
        .clk          (clk),
        .rstn         (rstn),
        .r_key        (vb_r_key),
        .victim_hit   (victim_hit),
        .victim_line  (victim_line),
        .victim_dirty (victim_dirty),
        .insert       (vb_insert),
        .w_key        (vb_w_key),
        .w_line       (vb_w_line),
        .w_dirty      (vb_w_dirty),
        .invalidate   (vb_invalidate),
        .evict_valid  (evict_valid),
        .evict_key    (evict_key),
        .evict_line   (evict_line),
        .evict_dirty  (evict_dirty)
    );

endmodule

/* dcache_ctrl.sv */
// controller of the L1 data cache: hit, victim swap, refill and write-back
// a swap or a refill writes the L1 line and returns to lookup, which then answers as a hit

`timescale 1ns/100ps

module dcache_ctrl import dcache_pkg::*, mem_bus_pkg::*; (
    input  logic               clk,
    input  logic               rstn,
    input  logic               cpu_req_valid,
    input  cpu_req_t           cpu_req,
    output logic               cpu_ready,
    output logic               cpu_resp_valid,
    output logic [31:0]        cpu_rdata,
    output logic [INDEX_W-1:0] l1_index,
    output logic               l1_we,
    output logic [TAG_W-1:0]   l1_w_tag,
    output line_t              l1_w_line,
    output logic               l1_w_dirty,
    input  logic [TAG_W-1:0]   l1_r_tag,
    input  logic               l1_r_valid,
    input  logic               l1_r_dirty,
    input  line_t              l1_r_line,
    output line_addr_t         vb_r_key,
    output logic               vb_insert,
    output line_addr_t         vb_w_key,
    output line_t              vb_w_line,
    output logic               vb_w_dirty,
    output logic               vb_invalidate,
    input  logic               victim_hit,
    input  line_t              victim_line,
    input  logic               victim_dirty,
    input  logic               evict_valid,
    input  line_addr_t         evict_key,
    input  line_t              evict_line,
    input  logic               evict_dirty,
    output logic               mem_req_valid,
    output mem_req_t           mem_req,
    input  logic               mem_resp_valid,
    input  line_t              mem_resp_line
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_WAIT_MEM
    } state_t;

    state_t     state_q;
    state_t     state_d;
    cpu_req_t   req_q;
    line_addr_t req_key;
    logic       l1_hit;
    line_t      merged_line;
    logic       mem_rd;
    logic       wb;

    assign req_key = {req_q.addr.tag, req_q.addr.index};
    assign l1_hit  = l1_r_valid && (l1_r_tag == req_q.addr.tag);

    assign cpu_ready = (state_q == ST_IDLE);
    assign cpu_rdata = l1_r_line[req_q.addr.word*32 +: 32];

    // store data merged into the current line
    always_comb begin
        merged_line = l1_r_line;
        merged_line[req_q.addr.word*32 +: 32] = req_q.wdata;
    end

    // displaced L1 line always goes to the victim buffer
    assign l1_index   = req_q.addr.index;
    assign l1_w_tag   = req_q.addr.tag;
    assign vb_r_key   = req_key;
    assign vb_w_key   = {l1_r_tag, req_q.addr.index};
    assign vb_w_line  = l1_r_line;
    assign vb_w_dirty = l1_r_dirty;

    always_comb begin
        state_d        = state_q;
        cpu_resp_valid = 1'b0;
        l1_we          = 1'b0;
        l1_w_line      = merged_line;
        l1_w_dirty     = 1'b1;
        vb_insert      = 1'b0;
        vb_invalidate  = 1'b0;
        mem_rd         = 1'b0;
        case (state_q)
            ST_IDLE: begin
                if (cpu_req_valid) begin
                    state_d = ST_LOOKUP;
                end
            end
            ST_LOOKUP: begin
                if (l1_hit) begin
                    cpu_resp_valid = 1'b1;
                    l1_we          = req_q.write;
                    state_d        = ST_IDLE;
                end else if (victim_hit) begin
                    // swap, the victim line moves into L1 with its dirty bit
                    l1_we         = 1'b1;
                    l1_w_line     = victim_line;
                    l1_w_dirty    = victim_dirty;
                    vb_invalidate = 1'b1;
                    vb_insert     = l1_r_valid;
                end else begin
                    mem_rd  = 1'b1;
                    state_d = ST_WAIT_MEM;
                end
            end
            ST_WAIT_MEM: begin
                if (mem_resp_valid) begin
                    l1_we      = 1'b1;
                    l1_w_line  = mem_resp_line;
                    l1_w_dirty = 1'b0;
                    vb_insert  = l1_r_valid;
                    state_d    = ST_LOOKUP;
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    // a slot that is both hit and overwritten moves to L1, so it needs no write-back
    assign wb = vb_insert && evict_valid && evict_dirty &&
                !(vb_invalidate && (evict_key == req_key));

    assign mem_req_valid = mem_rd || wb;
    assign mem_req.addr  = wb ? evict_key : req_key;
    assign mem_req.write = wb;
    assign mem_req.line  = wb ? evict_line : '0;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (cpu_req_valid && cpu_ready) begin
            req_q <= cpu_req;
        end
    end

endmodule

/* l1_line_array.sv */
// direct-mapped tag, valid, dirty and data storage of the L1 data cache
// one port: asynchronous read at index, write on we at the clock edge

`timescale 1ns/100ps

module l1_line_array import dcache_pkg::*; (
    input  logic               clk,
    input  logic               rstn,
    input  logic [INDEX_W-1:0] index,
    input  logic               we,
    input  logic [TAG_W-1:0]   w_tag,
    input  line_t              w_line,
    input  logic               w_dirty,
    output logic [TAG_W-1:0]   r_tag,
    output logic               r_valid,
    output logic               r_dirty,
    output line_t              r_line
);

    logic [NUM_SETS-1:0] valid_q;
    logic [NUM_SETS-1:0] dirty_q;
    logic [TAG_W-1:0]    tag_mem  [NUM_SETS];
    line_t               line_mem [NUM_SETS];

    // read path, no clock
    assign r_valid = valid_q[index];
    assign r_dirty = dirty_q[index];
    assign r_tag   = tag_mem[index];
    assign r_line  = line_mem[index];

    // status bits per set
    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (we) begin
            valid_q[index] <= 1'b1;
            dirty_q[index] <= w_dirty;
        end
    end

    // tag and data storage
    always_ff @(posedge clk) begin
        if (we) begin
            tag_mem[index]  <= w_tag;
            line_mem[index] <= w_line;
        end
    end

endmodule

/* victim_buffer.sv */
// fully associative victim store beside the L1 array
// combinational lookup on r_key, insertion at a round-robin counter

`timescale 1ns/100ps

module victim_buffer import dcache_pkg::*; #(
    parameter int VICTIM_ENTRIES = 2
) (
    input  logic       clk,
    input  logic       rstn,
    input  line_addr_t r_key,
    output logic       victim_hit,
    output line_t      victim_line,
    output logic       victim_dirty,
    input  logic       insert,
    input  line_addr_t w_key,
    input  line_t      w_line,
    input  logic       w_dirty,
    input  logic       invalidate,
    output logic       evict_valid,
    output line_addr_t evict_key,
    output line_t      evict_line,
    output logic       evict_dirty
);

    localparam int IDX_W = $clog2(VICTIM_ENTRIES);

    logic [VICTIM_ENTRIES-1:0] valid_q;
    logic [VICTIM_ENTRIES-1:0] dirty_q;
    line_addr_t                key_mem  [VICTIM_ENTRIES];
    line_t                     line_mem [VICTIM_ENTRIES];
    logic [IDX_W-1:0]          rr_cnt;
    logic [VICTIM_ENTRIES-1:0] hit_vec;
    logic [IDX_W-1:0]          hit_idx;

    // parallel compare, lowest numbered hit wins
    always_comb begin
        hit_idx = '0;
        for (int i = VICTIM_ENTRIES - 1; i >= 0; i--) begin
            hit_vec[i] = valid_q[i] && (key_mem[i] == r_key);
            if (hit_vec[i]) begin
                hit_idx = IDX_W'(i);
            end
        end
    end

    assign victim_hit   = |hit_vec;
    assign victim_line  = victim_hit ? line_mem[hit_idx] : '0;
    assign victim_dirty = victim_hit && dirty_q[hit_idx];

    // next slot to be overwritten
    assign evict_valid = valid_q[rr_cnt];
    assign evict_key   = key_mem[rr_cnt];
    assign evict_line  = line_mem[rr_cnt];
    assign evict_dirty = dirty_q[rr_cnt];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid_q <= '0;
            dirty_q <= '0;
            rr_cnt  <= '0;
        end else begin
            if (invalidate && victim_hit) begin
                valid_q[hit_idx] <= 1'b0;
            end
            // insert after invalidate so a swap into the same slot keeps the new line
            if (insert) begin
                valid_q[rr_cnt] <= 1'b1;
                dirty_q[rr_cnt] <= w_dirty;
                if (rr_cnt == IDX_W'(VICTIM_ENTRIES - 1)) begin
                    rr_cnt <= '0;
                end else begin
                    rr_cnt <= rr_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (insert) begin
            key_mem[rr_cnt]  <= w_key;
            line_mem[rr_cnt] <= w_line;
        end
    end

endmodule

/* mem_bus_pkg.sv */
// request structs for the word-wide CPU port and the line-wide memory port
// built on the address and line types of dcache_pkg

package mem_bus_pkg;

    import dcache_pkg::*;

    // one word access from the CPU
    typedef struct packed {
        cache_addr_t addr;
        logic        write;
        logic [31:0] wdata;
    } cpu_req_t;

    // line read or write-back towards memory
    typedef struct packed {
        line_addr_t addr;
        logic       write;
        line_t      line;
    } mem_req_t;

endpackage

/* dcache_pkg.sv */
// cache geometry and address layout shared by the L1 array, victim buffer and controller
// import with dcache_pkg::* in the module header

package dcache_pkg;

    // direct-mapped geometry, 64 sets of 64-byte lines
    localparam int NUM_SETS = 64;
    localparam int LINE_W   = 512;
    localparam int TAG_W    = 20;
    localparam int INDEX_W  = $clog2(NUM_SETS);
    localparam int WORD_W   = 4;
    localparam int BYTE_W   = 2;

    // one full line, word 0 in the low bits
    typedef logic [LINE_W-1:0] line_t;

    // byte address split into its cache fields
    typedef struct packed {
        logic [TAG_W-1:0]   tag;
        logic [INDEX_W-1:0] index;
        logic [WORD_W-1:0]  word;
        logic [BYTE_W-1:0]  byte_off;
    } cache_addr_t;

    // tag plus index, names one line in memory and keys the victim buffer
    typedef logic [TAG_W+INDEX_W-1:0] line_addr_t;

endpackage
